// File: hw/axi_read_pkg.sv
// Widths, counts and the slave-side ID layout of the AXI read crossbar, imported by every block
package axi_read_pkg;

    // ========================================
    // Topology
    // ========================================
    localparam int NUM_MASTERS = 2;
    localparam int NUM_SLAVES  = 2;

    // ========================================
    // AXI field widths
    // ========================================
    localparam int ADDR_BITS     = 32;
    localparam int DATA_BITS     = 32;
    localparam int ID_BITS       = 4;
    localparam int SLAVE_ID_BITS = 8;
    localparam int LEN_BITS      = 4;
    localparam int SIZE_BITS     = 3;
    localparam int BURST_BITS    = 2;
    localparam int RESP_BITS     = 2;

    // Address bit that picks slave 0 or slave 1
    localparam int SLAVE_SEL_BIT = 16;

    typedef logic [$clog2(NUM_MASTERS)-1:0] master_idx_t;
    typedef logic [$clog2(NUM_SLAVES)-1:0]  slave_idx_t;

    // Unused bits above the master index
    localparam int ID_PAD_BITS = SLAVE_ID_BITS - $bits(master_idx_t) - ID_BITS;

    // ========================================
    // Slave-side ID
    // ========================================
    // Flat word on the slave bus, split view for routing the return data
    typedef union packed {
        logic [SLAVE_ID_BITS-1:0] flat;
        struct packed {
            logic [ID_PAD_BITS-1:0] pad;
            master_idx_t            master;
            logic [ID_BITS-1:0]     id;
        } split;
    } slave_id_u;

endpackage

// File: hw/ar_target_decode.sv
// Per-master slave decode on the read address and one-outstanding-read tracking for the crossbar
`timescale 1ns/1ps

module ar_target_decode (
    input  logic                                                   ACLK,
    input  logic                                                   ARESETn,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   arvalid_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ADDR_BITS-1:0]
                                                                   araddr_m,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::NUM_MASTERS-1:0]
                                                                   ar_ready_to_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   r_done,
    output logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::NUM_MASTERS-1:0]
                                                                   req,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   arready_m
);

    import axi_read_pkg::*;

    slave_idx_t [NUM_MASTERS-1:0] tgt;
    slave_idx_t [NUM_MASTERS-1:0] tgt_r;
    slave_idx_t [NUM_MASTERS-1:0] ready_sel;
    logic       [NUM_MASTERS-1:0] busy;

    // ========================================
    // Decode and ready select
    // ========================================
    always_comb begin
        for (int m = 0; m < NUM_MASTERS; m++) begin
            tgt[m] = slave_idx_t'(araddr_m[m][SLAVE_SEL_BIT]);
            // Once busy, follow the locked port and not the live address
            ready_sel[m] = busy[m] ? tgt_r[m] : tgt[m];
            arready_m[m] = ar_ready_to_m[ready_sel[m]][m];
        end
    end

    // Requests only while the master has nothing in flight
    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                req[s][m] = arvalid_m[m] && !busy[m] && (tgt[m] == slave_idx_t'(s));
            end
        end
    end

    // ========================================
    // Outstanding read per master
    // ========================================
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            busy  <= '0;
            tgt_r <= '0;
        end else begin
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (arvalid_m[m] && arready_m[m]) begin
                    busy[m]  <= 1'b1;
                    tgt_r[m] <= tgt[m];
                end else if (r_done[m]) begin
                    // Free again the cycle after the last beat
                    busy[m] <= 1'b0;
                end
            end
        end
    end

endmodule

// File: hw/slave_read_port.sv
// One slave's read port: fixed-priority master grant, lock until the last beat, AR field mux
`timescale 1ns/1ps

module slave_read_port (
    input  logic                                                   ACLK,
    input  logic                                                   ARESETn,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   req,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ID_BITS-1:0]
                                                                   arid_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ADDR_BITS-1:0]
                                                                   araddr_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::LEN_BITS-1:0]
                                                                   arlen_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::SIZE_BITS-1:0]
                                                                   arsize_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::BURST_BITS-1:0]
                                                                   arburst_m,
    input  logic                                                   arready_s,
    input  logic                                                   rvalid_s,
    input  logic                                                   rlast_s,
    input  logic                                                   rready_s,
    output logic                                                   arvalid_s,
    output axi_read_pkg::slave_id_u                                arid_s,
    output logic [axi_read_pkg::ADDR_BITS-1:0]                     araddr_s,
    output logic [axi_read_pkg::LEN_BITS-1:0]                      arlen_s,
    output logic [axi_read_pkg::SIZE_BITS-1:0]                     arsize_s,
    output logic [axi_read_pkg::BURST_BITS-1:0]                    arburst_s,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   ar_ready_to_m
);

    import axi_read_pkg::*;

    // busy low is IDLE, high is BUSY
    logic        busy;
    logic        held;
    master_idx_t grant_r;
    master_idx_t pick;
    master_idx_t grant;
    logic        ar_hs;
    logic        last_hs;

    // ========================================
    // Arbitration
    // ========================================
    // Lowest index wins
    always_comb begin
        pick = master_idx_t'(0);
        for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
            if (req[m]) begin
                pick = master_idx_t'(m);
            end
        end
    end

    // A stalled address keeps its master until arready_s
    assign grant = held ? grant_r : pick;

    // ========================================
    // Address channel mux
    // ========================================
    always_comb begin
        arvalid_s   = !busy && req[grant];
        araddr_s    = araddr_m[grant];
        arlen_s     = arlen_m[grant];
        arsize_s    = arsize_m[grant];
        arburst_s   = arburst_m[grant];
        // Master index above the master's own ID
        arid_s.flat = {{ID_PAD_BITS{1'b0}}, grant, arid_m[grant]};
        for (int m = 0; m < NUM_MASTERS; m++) begin
            ar_ready_to_m[m] = arvalid_s && arready_s && (grant == master_idx_t'(m));
        end
    end

    assign ar_hs   = arvalid_s && arready_s;
    assign last_hs = rvalid_s && rready_s && rlast_s;

    // ========================================
    // Lock state
    // ========================================
    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            busy    <= 1'b0;
            held    <= 1'b0;
            grant_r <= '0;
        end else begin
            grant_r <= grant;
            held    <= arvalid_s && !arready_s;
            if (ar_hs) begin
                busy <= 1'b1;
            end else if (last_hs) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

// File: hw/read_return_router.sv
// Steers each slave's read beats to the master named in the slave ID and returns that master's RREADY
`timescale 1ns/1ps

module read_return_router (
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    rvalid_s,
    input  axi_read_pkg::slave_id_u [axi_read_pkg::NUM_SLAVES-1:0] rid_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::DATA_BITS-1:0]
                                                                   rdata_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::RESP_BITS-1:0]
                                                                   rresp_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    rlast_s,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   rready_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   rvalid_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ID_BITS-1:0]
                                                                   rid_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::DATA_BITS-1:0]
                                                                   rdata_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::RESP_BITS-1:0]
                                                                   rresp_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   rlast_m,
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                    rready_s,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   r_done
);

    import axi_read_pkg::*;

    master_idx_t [NUM_SLAVES-1:0] dest;

    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            dest[s] = rid_s[s].split.master;
        end
    end

    // ========================================
    // Return mux
    // ========================================
    // One outstanding read per master, so at most one slave hits each master
    always_comb begin
        rvalid_m = '0;
        rid_m    = '0;
        rdata_m  = '0;
        rresp_m  = '0;
        rlast_m  = '0;
        rready_s = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            for (int s = 0; s < NUM_SLAVES; s++) begin
                if (!rvalid_m[m] && rvalid_s[s] && (dest[s] == master_idx_t'(m))) begin
                    rvalid_m[m] = 1'b1;
                    rid_m[m]    = rid_s[s].split.id;
                    rdata_m[m]  = rdata_s[s];
                    rresp_m[m]  = rresp_s[s];
                    rlast_m[m]  = rlast_s[s];
                    rready_s[s] = rready_m[m];
                end
            end
        end
    end

    // Pulse on the master's last-beat handshake
    assign r_done = rvalid_m & rready_m & rlast_m;

endmodule

// File: hw/axi_read_xbar.sv
// Top level of the two-master, two-slave AXI read crossbar; connect masters and slaves here
`timescale 1ns/1ps

module axi_read_xbar (
    input  logic                                                   ACLK,
    input  logic                                                   ARESETn,

    // ========================================
    // Master side
    // ========================================
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   arvalid_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   arready_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ID_BITS-1:0]
                                                                   arid_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ADDR_BITS-1:0]
                                                                   araddr_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::LEN_BITS-1:0]
                                                                   arlen_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::SIZE_BITS-1:0]
                                                                   arsize_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::BURST_BITS-1:0]
                                                                   arburst_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   rvalid_m,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   rready_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::ID_BITS-1:0]
                                                                   rid_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::DATA_BITS-1:0]
                                                                   rdata_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0][axi_read_pkg::RESP_BITS-1:0]
                                                                   rresp_m,
    output logic [axi_read_pkg::NUM_MASTERS-1:0]                   rlast_m,

    // ========================================
    // Slave side
    // ========================================
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                    arvalid_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    arready_s,
    output logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::SLAVE_ID_BITS-1:0]
                                                                   arid_s,
    output logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::ADDR_BITS-1:0]
                                                                   araddr_s,
    output logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::LEN_BITS-1:0]
                                                                   arlen_s,
    output logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::SIZE_BITS-1:0]
                                                                   arsize_s,
    output logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::BURST_BITS-1:0]
                                                                   arburst_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    rvalid_s,
    output logic [axi_read_pkg::NUM_SLAVES-1:0]                    rready_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::SLAVE_ID_BITS-1:0]
                                                                   rid_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::DATA_BITS-1:0]
                                                                   rdata_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::RESP_BITS-1:0]
                                                                   rresp_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    rlast_s
);

    import axi_read_pkg::*;

    logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] req;
    logic [NUM_SLAVES-1:0][NUM_MASTERS-1:0] ar_ready_to_m;
    logic [NUM_MASTERS-1:0]                 r_done;

    ar_target_decode ar_target_decode_i (
        .ACLK          (ACLK),
        .ARESETn       (ARESETn),
        .arvalid_m     (arvalid_m),
        .araddr_m      (araddr_m),
        .ar_ready_to_m (ar_ready_to_m),
        .r_done        (r_done),
        .req           (req),
        .arready_m     (arready_m)
    );

    // One port per slave
    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        slave_read_port slave_read_port_i (
            .ACLK          (ACLK),
            .ARESETn       (ARESETn),
            .req           (req[s]),
            .arid_m        (arid_m),
            .araddr_m      (araddr_m),
            .arlen_m       (arlen_m),
            .arsize_m      (arsize_m),
            .arburst_m     (arburst_m),
            .arready_s     (arready_s[s]),
            .rvalid_s      (rvalid_s[s]),
            .rlast_s       (rlast_s[s]),
            .rready_s      (rready_s[s]),
            .arvalid_s     (arvalid_s[s]),
            .arid_s        (arid_s[s]),
            .araddr_s      (araddr_s[s]),
            .arlen_s       (arlen_s[s]),
            .arsize_s      (arsize_s[s]),
            .arburst_s     (arburst_s[s]),
            .ar_ready_to_m (ar_ready_to_m[s])
        );
    end

    read_return_router read_return_router_i (
        .rvalid_s (rvalid_s),
        .rid_s    (rid_s),
        .rdata_s  (rdata_s),
        .rresp_s  (rresp_s),
        .rlast_s  (rlast_s),
        .rready_m (rready_m),
        .rvalid_m (rvalid_m),
        .rid_m    (rid_m),
        .rdata_m  (rdata_m),
        .rresp_m  (rresp_m),
        .rlast_m  (rlast_m),
        .rready_s (rready_s),
        .r_done   (r_done)
    );

endmodule

// File: test/axi_read_xbar_asserts.sv
// Concurrent handshake checks on the read crossbar top level, bound in from the testbench
`timescale 1ns/1ps

module axi_read_xbar_asserts (
    input  logic                                                   ACLK,
    input  logic                                                   ARESETn,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    arvalid_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    arready_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0][axi_read_pkg::ADDR_BITS-1:0]
                                                                   araddr_s,
    input  logic [axi_read_pkg::NUM_SLAVES-1:0]                    rvalid_s,
    input  axi_read_pkg::slave_id_u [axi_read_pkg::NUM_SLAVES-1:0] rid_s,
    input  logic [axi_read_pkg::NUM_MASTERS-1:0]                   rvalid_m
);

    import axi_read_pkg::*;

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_ar
        ar_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
            arvalid_s[s] && !arready_s[s] |=> arvalid_s[s] && $stable(araddr_s[s]))
            else $error("arvalid_s[%0d] dropped or changed before arready_s", s);
    end

    rvalid_reset: assert property (@(posedge ACLK) !ARESETn |-> rvalid_m == '0)
        else $error("rvalid_m high during reset");

    // One read in flight per master, so two busy slaves serve two different masters
    one_master_each: assert property (@(posedge ACLK) disable iff (!ARESETn)
        &rvalid_s |-> rid_s[0].split.master != rid_s[1].split.master)
        else $error("two slaves return data to the same master");

endmodule

// File: test/tb_read_slave.sv
// Behavioral AXI read slave for the crossbar testbench; random arready, random gaps between beats
`timescale 1ns/1ps

module tb_read_slave #(
    parameter int          IDX  = 0,
    parameter logic [31:0] SALT = 32'h0
) (
    input  logic                                     ACLK,
    input  logic                                     ARESETn,
    input  logic                                     arvalid,
    output logic                                     arready,
    input  logic [axi_read_pkg::SLAVE_ID_BITS-1:0]   arid,
    input  logic [axi_read_pkg::ADDR_BITS-1:0]       araddr,
    input  logic [axi_read_pkg::LEN_BITS-1:0]        arlen,
    output logic                                     rvalid,
    input  logic                                     rready,
    output logic [axi_read_pkg::SLAVE_ID_BITS-1:0]   rid,
    output logic [axi_read_pkg::DATA_BITS-1:0]       rdata,
    output logic [axi_read_pkg::RESP_BITS-1:0]       rresp,
    output logic                                     rlast
);

    import axi_read_pkg::*;

    integer                   seed;
    logic                     busy;
    logic                     r_hs;
    logic [SLAVE_ID_BITS-1:0] id_r;
    logic [ADDR_BITS-1:0]     addr_r;
    logic [LEN_BITS-1:0]      len_r;
    logic [LEN_BITS-1:0]      beat;
    logic [31:0]              r;

    initial begin
        seed    = 21 + IDX;
        busy    = 1'b0;
        id_r    = '0;
        addr_r  = '0;
        len_r   = '0;
        beat    = '0;
        arready = 1'b0;
        rvalid  = 1'b0;
        rid     = '0;
        rdata   = '0;
        rresp   = '0;
        rlast   = 1'b0;
        forever begin
            @(posedge ACLK);
            r_hs = rvalid && rready;
            if (!ARESETn) begin
                busy = 1'b0;
            end else if (!busy && arvalid && arready) begin
                busy   = 1'b1;
                id_r   = arid;
                addr_r = araddr;
                len_r  = arlen;
                beat   = '0;
            end else if (busy && r_hs) begin
                if (beat == len_r) begin
                    busy = 1'b0;
                end else begin
                    beat = beat + 4'd1;
                end
            end
            #1;
            r       = $random(seed);
            arready = ARESETn && !busy && (r[1:0] != 2'b00);
            // A raised beat holds until it is taken
            if (!busy) begin
                rvalid = 1'b0;
            end else if (!rvalid || r_hs) begin
                rvalid = (r[3:2] != 2'b00);
            end
            rid   = id_r;
            rdata = (addr_r + {26'd0, beat, 2'b00}) ^ SALT ^ {4'(IDX), 28'd0};
            rlast = busy && (beat == len_r);
        end
    end

endmodule

// File: test/tb_axi_read_xbar.sv
// Testbench for the AXI read crossbar: two driven masters, two model slaves, per-beat checking
`timescale 1ns/1ps

module tb_axi_read_xbar;

    import axi_read_pkg::*;

    localparam logic [31:0]           DATA_SALT  = 32'h3C5A_9600;
    localparam int                    WAIT_LIMIT = 2000;
    localparam logic [SIZE_BITS-1:0]  AR_SIZE    = 3'd2;
    localparam logic [BURST_BITS-1:0] AR_BURST   = 2'b01;

    logic ACLK = 1'b0;
    logic ARESETn;

    logic [NUM_MASTERS-1:0]                 arvalid_m, arready_m, rvalid_m, rready_m, rlast_m;
    logic [NUM_MASTERS-1:0][ID_BITS-1:0]    arid_m, rid_m;
    logic [NUM_MASTERS-1:0][ADDR_BITS-1:0]  araddr_m;
    logic [NUM_MASTERS-1:0][LEN_BITS-1:0]   arlen_m;
    logic [NUM_MASTERS-1:0][SIZE_BITS-1:0]  arsize_m;
    logic [NUM_MASTERS-1:0][BURST_BITS-1:0] arburst_m;
    logic [NUM_MASTERS-1:0][DATA_BITS-1:0]  rdata_m;
    logic [NUM_MASTERS-1:0][RESP_BITS-1:0]  rresp_m;

    wire  [NUM_SLAVES-1:0]                    arvalid_s, arready_s, rvalid_s, rready_s, rlast_s;
    wire  [NUM_SLAVES-1:0][SLAVE_ID_BITS-1:0] arid_s, rid_s;
    wire  [NUM_SLAVES-1:0][ADDR_BITS-1:0]     araddr_s;
    wire  [NUM_SLAVES-1:0][LEN_BITS-1:0]      arlen_s;
    wire  [NUM_SLAVES-1:0][SIZE_BITS-1:0]     arsize_s;
    wire  [NUM_SLAVES-1:0][BURST_BITS-1:0]    arburst_s;
    wire  [NUM_SLAVES-1:0][DATA_BITS-1:0]     rdata_s;
    wire  [NUM_SLAVES-1:0][RESP_BITS-1:0]     rresp_s;

    // Scoreboard, one outstanding read per master
    integer               seed;
    int                   errors;
    int                   checks;
    logic                 random_rready;
    int                   issued [NUM_MASTERS];
    int                   completed [NUM_MASTERS];
    int                   beats_seen [NUM_MASTERS];
    int                   beats_expected [NUM_MASTERS];
    time                  first_beat_time [NUM_MASTERS];
    logic [ID_BITS-1:0]   exp_id [NUM_MASTERS];
    logic [ADDR_BITS-1:0] exp_addr [NUM_MASTERS];
    logic [LEN_BITS-1:0]  exp_len [NUM_MASTERS];
    logic [LEN_BITS-1:0]  beat_idx [NUM_MASTERS];

    always #4 ACLK = ~ACLK;

    axi_read_xbar axi_read_xbar_i (.*);

    for (genvar s = 0; s < NUM_SLAVES; s++) begin : g_slave
        tb_read_slave #(.IDX(s), .SALT(DATA_SALT)) slave_i (
            .ACLK    (ACLK),
            .ARESETn (ARESETn),
            .arvalid (arvalid_s[s]),
            .arready (arready_s[s]),
            .arid    (arid_s[s]),
            .araddr  (araddr_s[s]),
            .arlen   (arlen_s[s]),
            .rvalid  (rvalid_s[s]),
            .rready  (rready_s[s]),
            .rid     (rid_s[s]),
            .rdata   (rdata_s[s]),
            .rresp   (rresp_s[s]),
            .rlast   (rlast_s[s])
        );
    end

    bind axi_read_xbar axi_read_xbar_asserts asserts_i (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .arvalid_s (arvalid_s),
        .arready_s (arready_s),
        .araddr_s  (araddr_s),
        .rvalid_s  (rvalid_s),
        .rid_s     (rid_s),
        .rvalid_m  (rvalid_m)
    );

    function automatic logic [31:0] make_addr(input logic sel, input logic [13:0] word);
        return {15'd0, sel, word, 2'b00};
    endfunction

    // Word address of the beat, salted, slave index in the top nibble
    function automatic logic [31:0] expected_rdata(input logic slave, input logic [31:0] addr,
                                                   input logic [3:0] beat);
        logic [31:0] word;
        word = addr + 32'(beat) * 32'd4;
        return word ^ DATA_SALT ^ (32'(slave) << 28);
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("Timeout: %s", why);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic report_test(input int num, input string name, input int base);
        $display("Test %0d %s: %0d errors", num, name, errors - base);
    endtask

    // ========================================
    // Master side
    // ========================================
    task automatic do_read(input int m, input logic [3:0] id, input logic [31:0] addr,
                           input logic [3:0] len);
        int   n;
        logic hs;
        @(posedge ACLK);
        #1;
        arvalid_m[m] = 1'b1;
        arid_m[m]    = id;
        araddr_m[m]  = addr;
        arlen_m[m]   = len;
        arsize_m[m]  = AR_SIZE;
        arburst_m[m] = AR_BURST;
        hs = 1'b0;
        n  = 0;
        while (!hs && n < WAIT_LIMIT) begin
            @(posedge ACLK);
            hs = arready_m[m];
            n++;
        end
        if (!hs) abort_run($sformatf("master %0d never saw arready", m));
        exp_id[m]   = id;
        exp_addr[m] = addr;
        exp_len[m]  = len;
        issued[m]++;
        beats_expected[m] += int'(len) + 1;
        #1;
        arvalid_m[m] = 1'b0;
        n = 0;
        while (issued[m] != completed[m] && n < WAIT_LIMIT) begin
            @(posedge ACLK);
            n++;
        end
        if (issued[m] != completed[m]) abort_run($sformatf("master %0d read never ended", m));
    endtask

    task automatic random_read(input int m);
        logic [31:0] r;
        r = $random(seed);
        do_read(m, r[3:0], make_addr(r[4], r[18:5]), {1'b0, r[21:19]});
    endtask

    task automatic drive_rready();
        logic [31:0] r;
        forever begin
            @(posedge ACLK);
            #1;
            r = $random(seed);
            rready_m = random_rready ? r[1:0] : 2'b11;
        end
    endtask

    // ========================================
    // Beat checker
    // ========================================
    task automatic monitor_beats();
        forever begin
            @(posedge ACLK);
            for (int m = 0; m < NUM_MASTERS; m++) begin
                if (ARESETn && rvalid_m[m] && rready_m[m]) begin
                    beats_seen[m]++;
                    if (issued[m] == completed[m]) begin
                        $display("Unexpected beat: master %0d got data at %0t with no read open",
                                 m, $time);
                        errors++;
                    end else begin
                        check_value(rdata_m[m], expected_rdata(exp_addr[m][SLAVE_SEL_BIT],
                                    exp_addr[m], beat_idx[m]), "rdata_m");
                        check_value(32'(rid_m[m]), 32'(exp_id[m]), "rid_m");
                        check_value(32'(rresp_m[m]), 32'd0, "rresp_m");
                        check_value(32'(rlast_m[m]), 32'(beat_idx[m] == exp_len[m]), "rlast_m");
                        if (beat_idx[m] == 4'd0) first_beat_time[m] = $time;
                        if (beat_idx[m] == exp_len[m]) begin
                            beat_idx[m] = 4'd0;
                            completed[m]++;
                        end else begin
                            beat_idx[m] = beat_idx[m] + 4'd1;
                        end
                    end
                end
            end
            // Burst size and type as the slave receives them
            for (int s = 0; s < NUM_SLAVES; s++) begin
                if (ARESETn && arvalid_s[s] && arready_s[s]) begin
                    check_value(32'(arsize_s[s]), 32'(AR_SIZE), "arsize_s");
                    check_value(32'(arburst_s[s]), 32'(AR_BURST), "arburst_s");
                end
            end
        end
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        int base;
        seed          = 21;
        errors        = 0;
        checks        = 0;
        random_rready = 1'b0;
        ARESETn       = 1'b0;
        arvalid_m     = '0;
        arid_m        = '0;
        araddr_m      = '0;
        arlen_m       = '0;
        arsize_m      = '0;
        arburst_m     = '0;
        rready_m      = '0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            issued[m]          = 0;
            completed[m]       = 0;
            beats_seen[m]      = 0;
            beats_expected[m]  = 0;
            first_beat_time[m] = 0;
            beat_idx[m]        = '0;
        end
        fork
            monitor_beats();
            drive_rready();
        join_none

        base = errors;
        for (int c = 0; c < 18; c++) begin
            @(posedge ACLK);
            check_value(32'(arready_m), 32'd0, "arready_m after reset");
            check_value(32'(rvalid_m), 32'd0, "rvalid_m after reset");
            check_value(32'(arvalid_s), 32'd0, "arvalid_s after reset");
            if (c == 15) #1 ARESETn = 1'b1;
        end
        report_test(6, "reset state", base);

        base = errors;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            for (int s = 0; s < NUM_SLAVES; s++) begin
                do_read(m, 4'(m * 2 + s + 3), make_addr(1'(s), 14'(m * 64 + s * 8 + 4)), 4'd0);
            end
        end
        report_test(1, "single-beat reads", base);

        base = errors;
        for (int len = 0; len < 8; len++) begin
            do_read(len % 2, 4'(len), make_addr(1'(len / 2), 14'(len * 32)), 4'(len));
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            check_value(beats_seen[m], beats_expected[m], "beat count");
        end
        report_test(2, "burst lengths", base);

        base = errors;
        fork
            do_read(0, 4'hA, make_addr(1'b1, 14'h100), 4'd3);
            do_read(1, 4'hB, make_addr(1'b1, 14'h200), 4'd3);
        join
        check_value(32'(first_beat_time[0] < first_beat_time[1]), 32'd1, "master 0 first");
        report_test(3, "same-slave contention", base);

        base = errors;
        fork
            do_read(0, 4'h1, make_addr(1'b0, 14'h300), 4'd7);
            do_read(1, 4'h2, make_addr(1'b1, 14'h340), 4'd7);
        join
        report_test(4, "parallel slaves", base);

        base = errors;
        random_rready = 1'b1;
        fork
            repeat (100) random_read(0);
            repeat (100) random_read(1);
        join
        random_rready = 1'b0;
        for (int m = 0; m < NUM_MASTERS; m++) begin
            check_value(beats_seen[m], beats_expected[m], "beat count");
        end
        report_test(5, "random traffic", base);

        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
hw/axi_read_pkg.sv
hw/ar_target_decode.sv
hw/slave_read_port.sv
hw/read_return_router.sv
hw/axi_read_xbar.sv
test/axi_read_xbar_asserts.sv
test/tb_read_slave.sv
test/tb_axi_read_xbar.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the read crossbar testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_axi_read_xbar -f sources.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation OK" || { echo "Simulation not OK"; exit 1; }
